//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_cache -f tb.f -o tb_cache_sim

./obj_dir/tb_cache_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation finished without failures"

//--- source/cache.sv
`timescale 1ns/10ps

module cache
    import cache_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  valid,
    input  cpu_req_t              req,
    output logic                  addr_ok,
    output logic                  data_ok,
    output logic [word_w-1:0]     rdata,
    output logic                  rd_req,
    output logic [31:0]           rd_addr,
    input  logic                  rd_rdy,
    input  logic                  ret_valid,
    input  logic                  ret_last,
    input  logic [word_w-1:0]     ret_data,
    output logic                  wr_req,
    output logic [31:0]           wr_addr,
    output logic [line_w-1:0]     wr_data,
    input  logic                  wr_rdy
);

    logic [num_ways-1:0][tag_w-1:0]                      way_tag;
    logic [num_ways-1:0]                                 way_valid;
    logic [num_ways-1:0]                                 way_dirty;
    logic [num_ways-1:0][line_w-1:0]                     way_data;
    logic [index_w-1:0]                                  ram_index;
    logic [num_ways-1:0][words_per_line-1:0][word_w/8-1:0] bank_wen;
    logic [word_w-1:0]                                   bank_wdata;
    logic [num_ways-1:0]                                 tag_wen;
    logic [num_ways-1:0]                                 set_dirty;
    logic                                                refill_dirty;
    line_addr_u                                          refill_line;

    assign refill_line.raw = rd_addr;    // refill tag comes from the read address

    cache_ctrl u_ctrl (
        .clk, .resetn, .valid, .req, .addr_ok, .data_ok, .rdata,
        .way_tag, .way_valid, .way_dirty, .way_data,
        .ram_index, .bank_wen, .bank_wdata, .tag_wen, .set_dirty, .refill_dirty,
        .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy
    );

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        for (genvar b = 0; b < words_per_line; b++) begin : g_bank
            cache_data_bank u_bank (
                .clk   (clk),
                .addr  (ram_index),
                .wen   (bank_wen[w][b]),
                .wdata (bank_wdata),
                .rdata (way_data[w][b*word_w +: word_w])
            );
        end

        cache_tag_array u_tags (
            .clk       (clk),
            .resetn    (resetn),
            .addr      (ram_index),
            .wen       (tag_wen[w]),
            .wtag      (refill_line.fields.tag),
            .wdirty    (refill_dirty),
            .set_dirty (set_dirty[w]),
            .tag       (way_tag[w]),
            .valid     (way_valid[w]),
            .dirty     (way_dirty[w])
        );
    end

endmodule

//--- source/cache_ctrl.sv
`timescale 1ns/10ps

module cache_ctrl
    import cache_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   resetn,
    input  logic                                   valid,
    input  cpu_req_t                               req,
    output logic                                   addr_ok,
    output logic                                   data_ok,
    output logic [word_w-1:0]                      rdata,
    input  logic [num_ways-1:0][tag_w-1:0]         way_tag,
    input  logic [num_ways-1:0]                    way_valid,
    input  logic [num_ways-1:0]                    way_dirty,
    input  logic [num_ways-1:0][line_w-1:0]        way_data,
    output logic [index_w-1:0]                     ram_index,
    output logic [num_ways-1:0][words_per_line-1:0][word_w/8-1:0] bank_wen,
    output logic [word_w-1:0]                      bank_wdata,
    output logic [num_ways-1:0]                    tag_wen,
    output logic [num_ways-1:0]                    set_dirty,
    output logic                                   refill_dirty,
    output logic                                   rd_req,
    output logic [31:0]                            rd_addr,
    input  logic                                   rd_rdy,
    input  logic                                   ret_valid,
    input  logic                                   ret_last,
    input  logic [word_w-1:0]                      ret_data,
    output logic                                   wr_req,
    output logic [31:0]                            wr_addr,
    output logic [line_w-1:0]                      wr_data,
    input  logic                                   wr_rdy
);

    cache_state_t          state;
    cache_state_t          next_state;
    cpu_req_t              req_q;
    logic [bank_sel_w-1:0] word_sel;
    logic [bank_sel_w-1:0] beat_cnt;
    logic [7:0]            lfsr;
    logic                  victim;
    logic                  need_wb;
    logic [num_ways-1:0]   hit_way;
    logic                  hit;
    logic [word_w-1:0]     hit_word;
    logic [word_w-1:0]     merged_word;
    logic                  refill_beat;
    logic                  refill_done;
    line_addr_u            rd_line;
    line_addr_u            wr_line;

    assign word_sel    = req_q.offset[offset_w-1 -: bank_sel_w];
    assign victim      = lfsr[0];
    assign need_wb     = way_valid[victim] & way_dirty[victim];
    assign refill_beat = (state == refill) & ret_valid;
    assign refill_done = refill_beat & ret_last;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            idle:    if (valid) next_state = lookup;
            lookup:  next_state = hit ? idle : miss;
            miss:    if (wr_rdy || !need_wb) next_state = replace;  // clean victim skips wb
            replace: if (rd_rdy) next_state = refill;
            refill:  if (ret_valid && ret_last) next_state = idle;
            default: next_state = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (valid && addr_ok) begin
            req_q <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat_cnt <= '0;
            lfsr     <= lfsr_seed;
        end else if (refill_beat) begin
            beat_cnt <= ret_last ? '0 : beat_cnt + 1'b1;
            if (ret_last) begin
                lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            end
        end
    end

    // tag compare and hit word
    always_comb begin
        hit_word = '0;
        for (int w = 0; w < num_ways; w++) begin
            hit_way[w] = way_valid[w] && (way_tag[w] == req_q.tag);
            if (hit_way[w]) hit_word = way_data[w][word_sel*word_w +: word_w];
        end
    end
    assign hit = |hit_way;

    // store bytes folded into the returning word
    always_comb begin
        merged_word = ret_data;
        if (req_q.op && beat_cnt == word_sel) begin
            for (int b = 0; b < word_w/8; b++) begin
                if (req_q.wstrb[b]) merged_word[b*8 +: 8] = req_q.wdata[b*8 +: 8];
            end
        end
    end

    always_comb begin
        bank_wen = '0;
        tag_wen  = '0;
        if (state == lookup && hit && req_q.op) begin
            for (int w = 0; w < num_ways; w++) begin
                if (hit_way[w]) bank_wen[w][word_sel] = req_q.wstrb;
            end
        end else if (refill_beat) begin
            bank_wen[victim][beat_cnt] = '1;   // full word per beat
        end
        tag_wen[victim] = refill_done;
    end

    assign bank_wdata   = (state == lookup) ? req_q.wdata : merged_word;
    assign set_dirty    = {num_ways{state == lookup && req_q.op}} & hit_way;
    assign refill_dirty = req_q.op;       // store miss leaves the line dirty
    assign ram_index    = (state == idle) ? req.index : req_q.index;

    assign addr_ok = (state == idle);
    assign data_ok = ((state == lookup) & hit)
                   | (refill_beat & ~req_q.op & (beat_cnt == word_sel))
                   | (refill_done & req_q.op);
    assign rdata   = (state == lookup) ? hit_word : ret_data;

    assign rd_line.fields = '{tag: req_q.tag, index: req_q.index, offset: '0};
    assign wr_line.fields = '{tag: way_tag[victim], index: req_q.index, offset: '0};

    assign rd_req  = (state == replace);
    assign rd_addr = rd_line.raw;
    assign wr_req  = (state == miss) & need_wb;
    assign wr_addr = wr_line.raw;
    assign wr_data = way_data[victim];  // word 0 in the low bits

endmodule

//--- source/cache_data_bank.sv
`timescale 1ns/10ps

module cache_data_bank
    import cache_pkg::*;
(
    input  logic                  clk,
    input  logic [index_w-1:0]    addr,
    input  logic [word_w/8-1:0]   wen,     // byte enables
    input  logic [word_w-1:0]     wdata,
    output logic [word_w-1:0]     rdata
);

    logic [word_w-1:0] mem [num_sets];

    always_ff @(posedge clk) begin
        for (int b = 0; b < word_w/8; b++) begin
            if (wen[b]) begin
                mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
        rdata <= mem[addr];  // old data on a same-cycle write
    end

endmodule

//--- source/cache_pkg.sv
package cache_pkg;

    // geometry
    localparam int num_ways       = 2;
    localparam int num_sets       = 256;
    localparam int index_w        = 8;
    localparam int tag_w          = 20;
    localparam int offset_w       = 4;
    localparam int bank_sel_w     = 2;   // word select inside a line
    localparam int words_per_line = 4;
    localparam int word_w         = 32;
    localparam int line_w         = 128;

    localparam logic [7:0] lfsr_seed = 8'h01;  // victim lfsr reset value

    // main fsm, one-hot
    typedef enum logic [4:0] {
        idle    = 5'b00001,
        lookup  = 5'b00010,
        miss    = 5'b00100,
        replace = 5'b01000,
        refill  = 5'b10000
    } cache_state_t;

    typedef struct packed {
        logic                  op;      // 1 = store
        logic [index_w-1:0]    index;
        logic [tag_w-1:0]      tag;
        logic [offset_w-1:0]   offset;
        logic [word_w/8-1:0]   wstrb;
        logic [word_w-1:0]     wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [tag_w-1:0]      tag;
        logic [index_w-1:0]    index;
        logic [offset_w-1:0]   offset;
    } line_fields_t;

    // memory side address, raw word or split into fields
    typedef union packed {
        logic [31:0]           raw;
        line_fields_t          fields;
    } line_addr_u;

endpackage

//--- source/cache_tag_array.sv
`timescale 1ns/10ps

module cache_tag_array
    import cache_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [index_w-1:0]    addr,
    input  logic                  wen,        // refill, writes tag, valid and dirty
    input  logic [tag_w-1:0]      wtag,
    input  logic                  wdirty,
    input  logic                  set_dirty,  // store hit
    output logic [tag_w-1:0]      tag,
    output logic                  valid,
    output logic                  dirty
);

    logic [tag_w-1:0]    tag_mem [num_sets];
    logic [num_sets-1:0] valid_bits;
    logic [num_sets-1:0] dirty_bits;

    always_ff @(posedge clk) begin
        if (wen) begin
            tag_mem[addr] <= wtag;
        end
        tag <= tag_mem[addr];
    end

    // valid and dirty live in flops so reset can clear every set at once
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (wen) begin
            valid_bits[addr] <= 1'b1;
            dirty_bits[addr] <= wdirty;
        end else if (set_dirty) begin
            dirty_bits[addr] <= 1'b1;
        end
    end

    // registered read, lines up with the tag ram
    always_ff @(posedge clk) begin
        valid <= valid_bits[addr];
        dirty <= dirty_bits[addr];
    end

endmodule

//--- tb.f
source/cache_pkg.sv
source/cache_data_bank.sv
source/cache_tag_array.sv
source/cache_ctrl.sv
source/cache.sv
verification/tb_mem_model.sv
verification/tb_cache.sv

//--- verification/tb_cache.sv
`timescale 1ns/10ps

module tb_cache
    import cache_pkg::*;
();

    localparam int num_reqs     = 400;
    localparam int reset_cycles = 16;
    localparam logic [tag_w-1:0]   tag_pool   [4] = '{20'h12345, 20'h00abc, 20'hfff00, 20'h5a5a5};
    localparam logic [index_w-1:0] index_pool [4] = '{8'h00, 8'h37, 8'h80, 8'hff};

    logic              clk;
    logic              resetn;
    logic              valid;
    cpu_req_t          req;
    logic              addr_ok;
    logic              data_ok;
    logic [word_w-1:0] rdata;
    logic              rd_req;
    logic [31:0]       rd_addr;
    logic              rd_rdy;
    logic              ret_valid;
    logic              ret_last;
    logic [word_w-1:0] ret_data;
    logic              wr_req;
    logic [31:0]       wr_addr;
    logic [line_w-1:0] wr_data;
    logic              wr_rdy;

    integer            seed = 32'h7491_3051;
    logic [7:0]        ref_mem [logic [31:0]];  // bytes touched by stores
    logic [1:0]        last_tag_of [4];         // last tag slot per index slot
    logic [3:0]        index_seen;
    int                errors;
    int                protocol_errors;
    logic              rd_wait;
    logic              wr_wait;
    logic [31:0]       rd_addr_q;
    logic [31:0]       wr_addr_q;

    cache u_cache (
        .clk, .resetn, .valid, .req, .addr_ok, .data_ok, .rdata,
        .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy
    );

    tb_mem_model #(.seed_init(32'h7491_3051)) u_mem (
        .clk, .resetn, .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [7:0] hash_byte(input logic [31:0] addr);
        logic [31:0] h;
        h = addr * 32'h9e37_79b1;
        return h[31:24] ^ h[23:16] ^ h[15:8] ^ h[7:0];
    endfunction

    function automatic logic [7:0] ref_byte(input logic [31:0] addr);
        if (ref_mem.exists(addr)) return ref_mem[addr];
        return hash_byte(addr);  // untouched memory
    endfunction

    function automatic logic [word_w-1:0] ref_word(input logic [31:0] addr);
        logic [word_w-1:0] w;
        logic [31:0]       base;
        base = {addr[31:2], 2'b00};
        for (int b = 0; b < 4; b++) w[b*8 +: 8] = ref_byte(base + b);
        return w;
    endfunction

    function automatic logic [line_w-1:0] ref_line(input logic [31:0] addr);
        logic [line_w-1:0] l;
        for (int w = 0; w < words_per_line; w++) l[w*word_w +: word_w] = ref_word(addr + 4*w);
        return l;
    endfunction

    task automatic apply_store(input logic [31:0] addr, input logic [3:0] wstrb,
                               input logic [word_w-1:0] wdata);
        logic [31:0] base;
        base = {addr[31:2], 2'b00};
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) ref_mem[base + b] = wdata[b*8 +: 8];
        end
    endtask

    task automatic check_value(input string name, input logic [line_w-1:0] got,
                               input logic [line_w-1:0] exp);
        assert (got == exp) else begin
            errors++;
            $display("ERROR %0t %s: got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic make_req(output cpu_req_t r, output logic [1:0] idx_slot,
                            output logic [1:0] tag_slot);
        logic [31:0] rnd;
        logic [31:0] data;
        rnd      = $random(seed);
        data     = $random(seed);
        idx_slot = rnd[9:8];
        tag_slot = rnd[11:10];
        r.op     = (rnd[14:12] < 3'd3);  // roughly 3 in 8 are stores
        r.index  = index_pool[idx_slot];
        r.tag    = tag_pool[tag_slot];
        r.offset = {rnd[3:2], 2'b00};
        r.wstrb  = rnd[7:4];
        r.wdata  = data;
    endtask

    task automatic run_request(input cpu_req_t r, input logic [1:0] idx_slot,
                               input logic [1:0] tag_slot);
        logic [31:0] addr;
        logic [31:0] line_exp;
        line_addr_u  victim_line;
        int          cycles;
        int          ok_count;
        logic        saw_rd;
        logic        must_hit;
        addr     = {r.tag, r.index, r.offset};  // tag, index, byte offset
        line_exp = {r.tag, r.index, 4'h0};
        must_hit = index_seen[idx_slot] && (last_tag_of[idx_slot] == tag_slot);
        cycles   = 0;
        ok_count = 0;
        saw_rd   = 1'b0;
        @(negedge clk);
        valid = 1'b1;
        req   = r;
        @(posedge clk);
        while (!addr_ok) @(posedge clk);
        @(negedge clk);
        valid = 1'b0;
        req   = '0;
        do begin
            @(posedge clk);
            cycles++;
            if (rd_req) saw_rd = 1'b1;
            if (wr_req && wr_rdy) begin
                victim_line.raw = wr_addr;
                check_value("wr_addr",
                            line_w'({victim_line.fields.index, victim_line.fields.offset}),
                            line_w'({r.index, 4'h0}));
                check_value("wr_data", wr_data, ref_line(wr_addr));
            end
            if (rd_req && rd_rdy) check_value("rd_addr", line_w'(rd_addr), line_w'(line_exp));
            if (data_ok) begin
                ok_count++;
                if (must_hit) check_value("data_ok cycle", line_w'(cycles), line_w'(1));
                if (!r.op) check_value("rdata", line_w'(rdata), line_w'(ref_word(addr)));
                else apply_store(addr, r.wstrb, r.wdata);
            end
        end while (!addr_ok);
        assert (ok_count == 1) else begin
            errors++;
            $display("%0t request to %h got %0d data_ok pulses", $time, addr, ok_count);
        end
        assert (!(must_hit && saw_rd)) else begin
            errors++;
            $display("%0t resident line %h was read from memory", $time, line_exp);
        end
        last_tag_of[idx_slot] = tag_slot;
        index_seen[idx_slot]  = 1'b1;
    endtask

    // bus protocol under back-pressure
    initial begin
        protocol_errors = 0;
        rd_wait   = 1'b0;
        wr_wait   = 1'b0;
        rd_addr_q = '0;
        wr_addr_q = '0;
        forever begin
            @(posedge clk);
            if (resetn) begin
                assert (!(rd_req && wr_req)) else begin
                    protocol_errors++;
                    $display("%0t rd_req and wr_req were high together", $time);
                end
                assert (!rd_wait || (rd_req && rd_addr == rd_addr_q)) else begin
                    protocol_errors++;
                    $display("%0t rd_req or rd_addr changed before rd_rdy", $time);
                end
                assert (!wr_wait || (wr_req && wr_addr == wr_addr_q)) else begin
                    protocol_errors++;
                    $display("%0t wr_req or wr_addr changed before wr_rdy", $time);
                end
                assert (!(data_ok && addr_ok)) else begin
                    protocol_errors++;
                    $display("%0t data_ok raised with no request pending", $time);
                end
            end
            rd_wait   = rd_req && !rd_rdy;
            wr_wait   = wr_req && !wr_rdy;
            rd_addr_q = rd_addr;
            wr_addr_q = wr_addr;
        end
    end

    initial begin
        repeat (reset_cycles + num_reqs * 200) @(posedge clk);
        $display("watchdog expired before all requests completed");
        $display("Test failures found");
        $finish;
    end

    initial begin
        cpu_req_t   r;
        logic [1:0] idx_slot;
        logic [1:0] tag_slot;
        resetn     = 1'b0;
        valid      = 1'b0;
        req        = '0;
        errors     = 0;
        index_seen = '0;
        for (int i = 0; i < 4; i++) last_tag_of[i] = '0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        @(posedge clk);
        // idle outputs before any traffic
        check_value("addr_ok", line_w'(addr_ok), line_w'(1));
        check_value("data_ok", line_w'(data_ok), '0);
        check_value("rd_req", line_w'(rd_req), '0);
        check_value("wr_req", line_w'(wr_req), '0);
        for (int n = 0; n < num_reqs; n++) begin
            make_req(r, idx_slot, tag_slot);
            run_request(r, idx_slot, tag_slot);
        end
        repeat (4) @(posedge clk);
        $display("summary: %0d requests, %0d check errors, %0d protocol errors",
                 num_reqs, errors, protocol_errors);
        if (errors == 0 && protocol_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- verification/tb_mem_model.sv
`timescale 1ns/10ps

module tb_mem_model
    import cache_pkg::*;
#(
    parameter logic [31:0] seed_init = 32'h7491_3051
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              rd_req,
    input  logic [31:0]       rd_addr,
    output logic              rd_rdy,
    output logic              ret_valid,
    output logic              ret_last,
    output logic [word_w-1:0] ret_data,
    input  logic              wr_req,
    input  logic [31:0]       wr_addr,
    input  logic [line_w-1:0] wr_data,
    output logic              wr_rdy
);

    logic [line_w-1:0] lines [logic [31:0]];  // only lines that were written back
    integer            seed;
    logic              reading;
    logic [31:0]       read_addr;
    logic [1:0]        beat;

    // same hash as the reference model in tb_cache
    function automatic logic [7:0] hash_byte(input logic [31:0] addr);
        logic [31:0] h;
        h = addr * 32'h9e37_79b1;
        return h[31:24] ^ h[23:16] ^ h[15:8] ^ h[7:0];
    endfunction

    function automatic logic [line_w-1:0] line_at(input logic [31:0] addr);
        logic [line_w-1:0] l;
        if (lines.exists(addr)) return lines[addr];
        for (int b = 0; b < line_w/8; b++) begin
            l[b*8 +: 8] = hash_byte(addr + b);
        end
        return l;
    endfunction

    // drive side, falling edge
    initial begin
        logic [31:0]       rnd;
        logic [line_w-1:0] cur;
        seed      = seed_init;
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        forever begin
            @(negedge clk);
            rnd       = $random(seed);
            cur       = line_at(read_addr);
            rd_rdy    = resetn && (rnd[1:0] != 2'd0);  // stall about one cycle in four
            wr_rdy    = resetn && (rnd[3:2] != 2'd0);
            ret_valid = resetn && reading && (rnd[5:4] != 2'd0);  // random beat gaps
            ret_last  = ret_valid && (beat == 2'd3);
            ret_data  = ret_valid ? cur[beat*word_w +: word_w] : rnd;  // junk between beats
        end
    end

    // handshakes taken at the rising edge
    initial begin
        reading   = 1'b0;
        read_addr = '0;
        beat      = '0;
        forever begin
            @(posedge clk);
            if (!resetn) begin
                reading = 1'b0;
                beat    = '0;
            end else begin
                if (wr_req && wr_rdy) lines[wr_addr] = wr_data;
                if (reading && ret_valid) begin
                    beat = beat + 2'd1;
                    if (ret_last) reading = 1'b0;
                end
                if (rd_req && rd_rdy) begin
                    reading   = 1'b1;
                    read_addr = rd_addr;
                    beat      = '0;
                end
            end
        end
    end

endmodule
